/* verilog/cp_pkg.sv */
// Coprocessor shared definitions; fixed 64-bit data and 32-bit RV32 style instructions only
package cp_pkg;

    // Datapath and instruction sizes
    localparam int DATA_WIDTH     = 64;
    localparam int INST_WIDTH     = 32;
    localparam int CP_REG_NUM     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // custom-0 major opcode
    localparam logic [6:0] CUSTOM0_OPCODE = 7'b0001011;

    // Cycles spent in EXEC for multiply where all other ops take one
    localparam logic [2:0] MUL_LATENCY = 3'd4;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        WRITEBACK
    } cp_state_e;

    // Selected by funct3; 4 to 7 are illegal
    typedef enum logic [2:0] {
        OP_WRITE = 3'd0,
        OP_READ  = 3'd1,
        OP_ADD   = 3'd2,
        OP_MUL   = 3'd3
    } cp_op_e;

    typedef struct packed {
        logic                  valid;
        logic [INST_WIDTH-1:0] instr;
        logic [DATA_WIDTH-1:0] rs1_data;
    } cp_inst_t;

    typedef struct packed {
        cp_op_e                    op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [DATA_WIDTH-1:0]     rs1_data;
    } cp_req_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     data;
    } cp_wb_t;

endpackage

/* verilog/cp_latency_timer.sv */
// Latency down counter; latency must be 1 to 7, done is high while the count is 1
module cp_latency_timer (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [2:0] latency,
    output logic       done
);

    logic [2:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= latency;
        end else if (count != 3'd0) begin
            count <= count - 3'd1;
        end
    end

    // Last execution cycle
    assign done = (count == 3'd1);

endmodule

/* verilog/cp_exec_unit.sv */
// Coprocessor execute unit; multiply is a multicycle path covered by the timer latency
module cp_exec_unit import cp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  cp_req_t               req,
    input  logic [DATA_WIDTH-1:0] operand_a,
    input  logic [DATA_WIDTH-1:0] operand_b,
    input  logic                  capture,
    output logic [DATA_WIDTH-1:0] result
);

    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] product;
    logic [DATA_WIDTH-1:0] result_next;

    // Both wrap modulo 2^64
    assign sum     = operand_a + operand_b;
    // Low half of the product only
    assign product = operand_a * operand_b;

    always_comb begin
        unique case (req.op)
            OP_WRITE: result_next = req.rs1_data;
            OP_READ:  result_next = operand_a;
            OP_ADD:   result_next = sum;
            OP_MUL:   result_next = product;
            default:  result_next = '0;
        endcase
    end

    // Captured on the timer's last count cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (capture) begin
            result <= result_next;
        end
    end

endmodule

/* verilog/cp_register_bank.sv */
// Coprocessor register bank, 32 x 64; reset clears every entry, reads are combinational
module cp_register_bank import cp_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      write_en,
    input  logic [REG_ADDR_WIDTH-1:0] write_addr,
    input  logic [DATA_WIDTH-1:0]     data_in,
    input  logic [REG_ADDR_WIDTH-1:0] read_addr_a,
    input  logic [REG_ADDR_WIDTH-1:0] read_addr_b,
    output logic [DATA_WIDTH-1:0]     data_out_a,
    output logic [DATA_WIDTH-1:0]     data_out_b
);

    logic [DATA_WIDTH-1:0] regs [CP_REG_NUM];

    // Clear takes one cycle for the whole array
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < CP_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= data_in;
        end
    end

    // New data shows the cycle after the write
    assign data_out_a = regs[read_addr_a];
    assign data_out_b = regs[read_addr_b];

endmodule

/* verilog/cp_dispatcher.sv */
// Coprocessor dispatcher; one instruction in flight, inputs ignored while stall is high
module cp_dispatcher import cp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  cp_inst_t              inst,
    input  logic                  timer_done,
    input  logic [DATA_WIDTH-1:0] result,
    output logic                  timer_start,
    output logic [2:0]            timer_latency,
    output cp_req_t               req,
    output logic                  stall,
    output logic                  exception,
    output logic                  reg_write,
    output cp_wb_t                int_wb
);

    cp_state_e  state;
    cp_state_e  state_next;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_custom;
    logic       legal_op;
    logic       accept;
    logic       illegal;

    // R-type field decode
    assign opcode = inst.instr[6:0];
    assign funct3 = inst.instr[14:12];

    assign is_custom = inst.valid && (opcode == CUSTOM0_OPCODE);
    // Only funct3 0 to 3 are defined
    assign legal_op  = (funct3[2] == 1'b0);
    assign accept    = (state == IDLE) && is_custom && legal_op;
    assign illegal   = (state == IDLE) && is_custom && !legal_op;

    // Timer loads at the accepting edge
    assign timer_start   = accept;
    assign timer_latency = (funct3 == OP_MUL) ? MUL_LATENCY : 3'd1;

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (accept) begin
                    state_next = EXEC;
                end
            end
            EXEC: begin
                if (timer_done) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            exception <= 1'b0;
        end else begin
            state     <= state_next;
            exception <= illegal;
        end
    end

    // Request fields held for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op       <= cp_op_e'(funct3);
            req.rd       <= inst.instr[11:7];
            req.rs1      <= inst.instr[19:15];
            req.rs2      <= inst.instr[24:20];
            req.rs1_data <= inst.rs1_data;
        end
    end

    // Busy from the cycle after accept through writeback
    assign stall = (state != IDLE);

    // Read returns to the integer side and everything else lands in the bank
    assign reg_write    = (state == WRITEBACK) && (req.op != OP_READ);
    assign int_wb.valid = (state == WRITEBACK) && (req.op == OP_READ);
    assign int_wb.rd    = req.rd;
    assign int_wb.data  = result;

endmodule

/* verilog/cp_top.sv */
// Coprocessor top; caller must hold off new instructions while stall is high
module cp_top import cp_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cp_inst_t inst,
    output logic     stall,
    output logic     exception,
    output cp_wb_t   int_wb
);

    cp_req_t               req;
    logic                  timer_start;
    logic [2:0]            timer_latency;
    logic                  timer_done;
    logic                  reg_write;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    logic [DATA_WIDTH-1:0] result;

    cp_dispatcher dispatcher_i (
        .clk           (clk),
        .reset         (reset),
        .inst          (inst),
        .timer_done    (timer_done),
        .result        (result),
        .timer_start   (timer_start),
        .timer_latency (timer_latency),
        .req           (req),
        .stall         (stall),
        .exception     (exception),
        .reg_write     (reg_write),
        .int_wb        (int_wb)
    );

    cp_latency_timer timer_i (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .latency (timer_latency),
        .done    (timer_done)
    );

    // Result captured on the same edge the dispatcher leaves EXEC
    cp_exec_unit exec_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .capture   (timer_done),
        .result    (result)
    );

    cp_register_bank bank_i (
        .clk         (clk),
        .reset       (reset),
        .write_en    (reg_write),
        .write_addr  (req.rd),
        .data_in     (result),
        .read_addr_a (req.rs1),
        .read_addr_b (req.rs2),
        .data_out_a  (operand_a),
        .data_out_b  (operand_b)
    );

endmodule

/* test/cp_top_asserts.sv */
// Port level checks only, sampled on the rising clock; bound into every cp_top instance
module cp_top_asserts import cp_pkg::*; (
    input logic   clk,
    input logic   reset,
    input logic   stall,
    input logic   exception,
    input cp_wb_t int_wb
);

    // Writeback happens in the WRITEBACK state, which still stalls
    wb_under_stall: assert property (@(posedge clk) disable iff (reset)
        int_wb.valid |-> stall)
        else $error("integer writeback seen while stall is low");

    // Illegal funct3 never leaves IDLE
    exception_no_stall: assert property (@(posedge clk) disable iff (reset)
        exception |-> !stall)
        else $error("exception pulse seen while stall is high");

    // Reset forces IDLE at the next edge
    reset_clears_stall: assert property (@(posedge clk)
        reset |=> !stall)
        else $error("stall high following a reset cycle");

endmodule

bind cp_top cp_top_asserts asserts_i (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .exception (exception),
    .int_wb    (int_wb)
);

/* test/tb_cp_top.sv */
// Reads test/cp_patterns.hex from the project root; one instruction at a time, stall must fall first
module tb_cp_top import cp_pkg::*; ();

    localparam int NUM_PATTERNS   = 25;
    localparam int WORDS_PER_LINE = 5;
    localparam int WAIT_LIMIT     = 20;

    // Check column codes in the pattern file
    localparam logic [3:0] CHECK_WB    = 4'd1;
    localparam logic [3:0] CHECK_STALL = 4'd2;

    logic     clk;
    logic     reset;
    cp_inst_t inst;
    logic     stall;
    logic     exception;
    cp_wb_t   int_wb;

    logic [63:0] pattern_mem [NUM_PATTERNS*WORDS_PER_LINE];
    int          mismatch_count;
    int          timeout_count;

    cp_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .stall     (stall),
        .exception (exception),
        .int_wb    (int_wb)
    );

    always #10 clk = ~clk;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // All waits sample on the falling edge, away from the registered updates
    task automatic wait_for_stall(input logic level, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = (stall == level);
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout at time %0t: stall never went to %0b", $time, level);
        end
    endtask

    task automatic wait_for_wb(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = int_wb.valid;
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout at time %0t: no integer writeback arrived", $time);
        end
    endtask

    task automatic wait_for_exception(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = exception;
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout at time %0t: no exception pulse arrived", $time);
        end
    endtask

    // Number of falling edges with stall high, starting at the first one
    task automatic measure_stall(output int cycles);
        logic seen;
        cycles = 0;
        wait_for_stall(1'b1, seen);
        if (seen) begin
            cycles = 1;
            for (int n = 0; n < WAIT_LIMIT; n++) begin
                @(negedge clk);
                if (!stall) begin
                    break;
                end
                cycles++;
            end
        end
    endtask

    // Valid for one cycle and accepted at the following rising edge
    task automatic drive_instruction(input logic [31:0] instr, input logic [63:0] rs1_data);
        @(posedge clk);
        inst.valid    <= 1'b1;
        inst.instr    <= instr;
        inst.rs1_data <= rs1_data;
        @(posedge clk);
        inst.valid <= 1'b0;
    endtask

    initial begin
        int          idle_cycles;
        int          stall_cycles;
        logic        seen;
        logic [31:0] instr;
        logic [63:0] rs1_data;
        logic [3:0]  check_kind;
        logic [63:0] expected;
        logic        expect_exc;

        mismatch_count = 0;
        timeout_count  = 0;
        clk            = 1'b0;
        reset          = 1'b1;
        inst           = '0;
        void'($urandom(32'hed35));
        $readmemh("test/cp_patterns.hex", pattern_mem);

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(64'(stall), 64'd0, "stall after reset");
        check_value(64'(exception), 64'd0, "exception after reset");
        check_value(64'(int_wb.valid), 64'd0, "int_wb valid after reset");

        for (int i = 0; i < NUM_PATTERNS; i++) begin
            instr       = pattern_mem[i*WORDS_PER_LINE][31:0];
            rs1_data    = pattern_mem[i*WORDS_PER_LINE+1];
            check_kind  = pattern_mem[i*WORDS_PER_LINE+2][3:0];
            expected    = pattern_mem[i*WORDS_PER_LINE+3];
            expect_exc  = pattern_mem[i*WORDS_PER_LINE+4][0];
            idle_cycles = $urandom_range(3, 0);
            repeat (idle_cycles) @(posedge clk);
            drive_instruction(instr, rs1_data);

            if (expect_exc) begin
                wait_for_exception(seen);
                if (seen) begin
                    check_value(64'(stall), 64'd0, "stall during exception");
                    check_value(64'(int_wb.valid), 64'd0, "writeback during exception");
                    @(negedge clk);
                    check_value(64'(exception), 64'd0, "exception longer than one cycle");
                end
            end else if (check_kind == CHECK_WB) begin
                // A legal op raises no exception after its accepting edge
                @(negedge clk);
                check_value(64'(exception), 64'd0, "exception on read");
                wait_for_wb(seen);
                if (seen) begin
                    check_value(int_wb.data, expected, "read data");
                    check_value(64'(int_wb.rd), 64'(instr[11:7]), "read rd");
                end
            end else if (check_kind == CHECK_STALL) begin
                measure_stall(stall_cycles);
                check_value(64'(stall_cycles), expected, "stall cycles");
            end else begin
                // Foreign opcode leaves everything idle
                repeat (2) begin
                    @(negedge clk);
                    check_value(64'(stall), 64'd0, "stall on foreign opcode");
                    check_value(64'(exception), 64'd0, "exception on foreign opcode");
                    check_value(64'(int_wb.valid), 64'd0, "writeback on foreign opcode");
                end
            end
            wait_for_stall(1'b0, seen);
        end

        $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* test/cp_patterns.hex */
// instruction, rs1 data, check (0 none, 1 int_wb data, 2 stall cycles), expected, exception
// read patterns expect int_wb.rd equal to instruction bits 11:7
0002918B 0000000000000000 1 0000000000000000 0
000F9F8B 0000000000000000 1 0000000000000000 0
0000008B 0123456789ABCDEF 2 0000000000000002 0
0000950B 0000000000000000 1 0123456789ABCDEF 0
0000010B FFFFFFFFFFFFFFFF 2 0000000000000002 0
0000018B 0000000000000005 2 0000000000000002 0
0031220B 0000000000000000 2 0000000000000002 0
0002120B 0000000000000000 1 0000000000000004 0
0010A28B 0000000000000000 2 0000000000000002 0
0002930B 0000000000000000 1 02468ACF13579BDE 0
0000030B 0000000100000001 2 0000000000000002 0
0063338B 0000000000000000 2 0000000000000005 0
0003958B 0000000000000000 1 0000000200000001 0
0031340B 0000000000000000 2 0000000000000005 0
0004160B 0000000000000000 1 FFFFFFFFFFFFFFFB 0
0000408B AAAAAAAAAAAAAAAA 0 0000000000000000 1
0000718B AAAAAAAAAAAAAAAA 0 0000000000000000 1
0000968B 0000000000000000 1 0123456789ABCDEF 0
0001970B 0000000000000000 1 0000000000000005 0
000000B3 5555555555555555 0 0000000000000000 0
000001AB 5555555555555555 0 0000000000000000 0
0000978B 0000000000000000 1 0123456789ABCDEF 0
0001980B 0000000000000000 1 0000000000000005 0
00000F8B 8000000000000001 2 0000000000000002 0
01FFAF0B 0000000000000000 2 0000000000000002 0

/* tb.f */
verilog/cp_pkg.sv
verilog/cp_latency_timer.sv
verilog/cp_exec_unit.sv
verilog/cp_register_bank.sv
verilog/cp_dispatcher.sv
verilog/cp_top.sv
test/cp_top_asserts.sv
test/tb_cp_top.sv

/* Makefile */
SIM        := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TOP        := tb_cp_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Run from the project root so the pattern file path resolves
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
